/* exec_pkg.sv */
package exec_pkg;

    // widths
    parameter int XLEN        = 32;
    parameter int REG_ADDR_W  = 5;
    parameter int SRAM_ADDR_W = 12;
    parameter int BR_ADDR_W   = 12;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_LB,
        OP_LH,
        OP_LW,
        OP_LBU,
        OP_LHU,
        OP_SB,
        OP_SH,
        OP_SW
    } alu_op_e;

    // two address bits right above the sram word address
    typedef enum logic [1:0] {
        SRAM_IRAM = 2'b00,
        SRAM_ORAM = 2'b01,
        SRAM_WRAM = 2'b10,
        SRAM_NONE = 2'b11
    } sram_sel_e;

endpackage

/* int_alu.sv */
`timescale 1ns/1ps

module int_alu #(
    parameter int XLEN = exec_pkg::XLEN
) (
    input  exec_pkg::alu_op_e op,
    input  logic [XLEN-1:0]   src1,
    input  logic [XLEN-1:0]   src2,
    input  logic [XLEN-1:0]   pc,
    output logic [XLEN-1:0]   result
);

    import exec_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = src2[4:0];

    // two's complement compare
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (op)
            OP_ADD: begin
                result = src1 + src2;
            end
            OP_SUB: begin
                result = src1 - src2;
            end
            OP_SLT: begin
                result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            OP_SLTU: begin
                result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            OP_XOR: begin
                result = src1 ^ src2;
            end
            OP_OR: begin
                result = src1 | src2;
            end
            OP_AND: begin
                result = src1 & src2;
            end
            OP_SLL: begin
                result = src1 << shamt;
            end
            OP_SRL: begin
                result = src1 >> shamt;
            end
            OP_SRA: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            // upper immediate arrives already shifted in src2
            OP_LUI: begin
                result = src2;
            end
            OP_AUIPC: begin
                result = pc + src2;
            end
            // link value
            OP_JAL, OP_JALR: begin
                result = pc + XLEN'(4);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve #(
    parameter int XLEN      = exec_pkg::XLEN,
    parameter int BR_ADDR_W = exec_pkg::BR_ADDR_W
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 accept,
    input  exec_pkg::alu_op_e    op,
    input  logic [XLEN-1:0]      src1,
    input  logic [XLEN-1:0]      src2,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      pc,
    output logic                 br_vld,
    output logic [BR_ADDR_W-1:0] br_addr
);

    import exec_pkg::*;

    logic            cond;
    logic            jump;
    logic [XLEN-1:0] target;

    always_comb begin
        case (op)
            OP_BEQ:  cond = src1 == src2;
            OP_BNE:  cond = src1 != src2;
            OP_BLT:  cond = $signed(src1) < $signed(src2);
            OP_BGE:  cond = $signed(src1) >= $signed(src2);
            OP_BLTU: cond = src1 < src2;
            OP_BGEU: cond = src1 >= src2;
            default: cond = 1'b0;
        endcase
    end

    assign jump = (op == OP_JAL) || (op == OP_JALR);

    always_comb begin
        case (op)
            OP_JAL:  target = pc + src2;
            OP_JALR: target = src1 + src2;
            default: target = pc + imm;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            br_vld <= 1'b0;
        end else begin
            br_vld <= accept && (cond || jump);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr <= target[BR_ADDR_W-1:0];
        end
    end

    // the redirect squashes the next accept, so it can't repeat
    a_br_single: assert property (@(posedge clk) disable iff (!arst_n) br_vld |=> !br_vld);

endmodule

/* mem_addr_gen.sv */
`timescale 1ns/1ps

module mem_addr_gen #(
    parameter int XLEN        = exec_pkg::XLEN,
    parameter int SRAM_ADDR_W = exec_pkg::SRAM_ADDR_W
) (
    input  exec_pkg::alu_op_e      op,
    input  logic [XLEN-1:0]        src1,
    input  logic [XLEN-1:0]        src2,
    input  logic [XLEN-1:0]        imm,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output exec_pkg::sram_sel_e    sram_sel,
    output logic                   is_load
);

    import exec_pkg::*;

    logic            is_store;
    logic [XLEN-1:0] addr;

    always_comb begin
        case (op)
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: is_load = 1'b1;
            default: is_load = 1'b0;
        endcase
    end

    assign is_store = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);

    // loads carry the offset in src2, stores in imm
    assign addr = is_load ? src1 + src2 : src1 + imm;

    always_comb begin
        if (is_load || is_store) begin
            sram_addr = addr[SRAM_ADDR_W-1:0];
            sram_sel  = sram_sel_e'(addr[SRAM_ADDR_W+1:SRAM_ADDR_W]);
        end else begin
            sram_addr = '0;
            sram_sel  = SRAM_NONE;
        end
    end

endmodule

/* ex_lsu_reg.sv */
`timescale 1ns/1ps

module ex_lsu_reg #(
    parameter int XLEN        = exec_pkg::XLEN,
    parameter int SRAM_ADDR_W = exec_pkg::SRAM_ADDR_W
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            idu_vld,
    input  logic                            idu_wb_en,
    input  logic [exec_pkg::REG_ADDR_W-1:0] idu_wb_addr,
    input  exec_pkg::alu_op_e               op,
    input  logic [XLEN-1:0]                 src2,
    input  logic [XLEN-1:0]                 alu_result,
    input  logic [SRAM_ADDR_W-1:0]          sram_addr,
    input  exec_pkg::sram_sel_e             sram_sel,
    input  logic                            lsu_rdy,
    input  logic                            br_vld,
    output logic                            accept,
    output logic                            wb_vld,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output exec_pkg::alu_op_e               lsu_op,
    output logic [exec_pkg::REG_ADDR_W-1:0] lsu_wb_addr,
    output logic [XLEN-1:0]                 lsu_wb_data,
    output logic [XLEN-1:0]                 lsu_store_data,
    output logic [SRAM_ADDR_W-1:0]          lsu_sram_addr,
    output exec_pkg::sram_sel_e             lsu_sram_sel
);

    // instruction behind a redirect is dropped
    assign accept = idu_vld && lsu_rdy && !br_vld;
    assign wb_vld = accept && idu_wb_en;

    // slot only moves when the lsu takes the current item
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lsu_vld    <= 1'b0;
            lsu_wb_vld <= 1'b0;
        end else if (lsu_rdy) begin
            lsu_vld    <= accept;
            lsu_wb_vld <= accept && idu_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lsu_op         <= op;
            lsu_wb_addr    <= idu_wb_addr;
            lsu_wb_data    <= alu_result;
            lsu_store_data <= src2;
            lsu_sram_addr  <= sram_addr;
            lsu_sram_sel   <= sram_sel;
        end
    end

    // stalled item stays put until the lsu takes it
    a_lsu_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        lsu_vld && !lsu_rdy |=> lsu_vld && $stable(lsu_wb_vld)
            && $stable({lsu_op, lsu_wb_addr, lsu_wb_data, lsu_store_data,
                        lsu_sram_addr, lsu_sram_sel})
    );

endmodule

/* exec_stage.sv */
`timescale 1ns/1ps

module exec_stage #(
    parameter int XLEN        = exec_pkg::XLEN,
    parameter int SRAM_ADDR_W = exec_pkg::SRAM_ADDR_W,
    parameter int BR_ADDR_W   = exec_pkg::BR_ADDR_W
) (
    input  logic                            clk,
    input  logic                            arst_n,
    // decode side
    input  logic                            idu_vld,
    input  exec_pkg::alu_op_e               idu_op,
    input  logic [XLEN-1:0]                 idu_src1,
    input  logic [XLEN-1:0]                 idu_src2,
    input  logic [XLEN-1:0]                 idu_imm,
    input  logic [XLEN-1:0]                 idu_pc,
    input  logic                            idu_wb_en,
    input  logic [exec_pkg::REG_ADDR_W-1:0] idu_wb_addr,
    output logic                            idu_rdy,
    output logic                            idu_flush,
    output logic                            wb_vld,
    output logic [exec_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [XLEN-1:0]                 wb_data,
    output logic                            wb_is_load,
    // fetch redirect
    output logic                            ifu_br_vld,
    output logic [BR_ADDR_W-1:0]            ifu_br_addr,
    // load/store unit
    input  logic                            lsu_rdy,
    output logic                            lsu_vld,
    output logic                            lsu_wb_vld,
    output exec_pkg::alu_op_e               lsu_op,
    output logic [exec_pkg::REG_ADDR_W-1:0] lsu_wb_addr,
    output logic [XLEN-1:0]                 lsu_wb_data,
    output logic [XLEN-1:0]                 lsu_store_data,
    output logic [SRAM_ADDR_W-1:0]          lsu_sram_addr,
    output exec_pkg::sram_sel_e             lsu_sram_sel
);

    import exec_pkg::*;

    logic                   accept;
    logic [SRAM_ADDR_W-1:0] sram_addr;
    sram_sel_e              sram_sel;

    assign idu_rdy   = lsu_rdy;
    assign idu_flush = ifu_br_vld;
    assign wb_addr   = idu_wb_addr;

    int_alu #(.XLEN(XLEN)) i_int_alu (
        .op(idu_op), .src1(idu_src1), .src2(idu_src2), .pc(idu_pc), .result(wb_data)
    );

    branch_resolve #(.XLEN(XLEN), .BR_ADDR_W(BR_ADDR_W)) i_branch_resolve (
        .clk(clk), .arst_n(arst_n), .accept(accept), .op(idu_op),
        .src1(idu_src1), .src2(idu_src2), .imm(idu_imm), .pc(idu_pc),
        .br_vld(ifu_br_vld), .br_addr(ifu_br_addr)
    );

    mem_addr_gen #(.XLEN(XLEN), .SRAM_ADDR_W(SRAM_ADDR_W)) i_mem_addr_gen (
        .op(idu_op), .src1(idu_src1), .src2(idu_src2), .imm(idu_imm),
        .sram_addr(sram_addr), .sram_sel(sram_sel), .is_load(wb_is_load)
    );

    ex_lsu_reg #(.XLEN(XLEN), .SRAM_ADDR_W(SRAM_ADDR_W)) i_ex_lsu_reg (
        .clk(clk), .arst_n(arst_n), .idu_vld(idu_vld), .idu_wb_en(idu_wb_en),
        .idu_wb_addr(idu_wb_addr), .op(idu_op), .src2(idu_src2), .alu_result(wb_data),
        .sram_addr(sram_addr), .sram_sel(sram_sel), .lsu_rdy(lsu_rdy),
        .br_vld(ifu_br_vld), .accept(accept), .wb_vld(wb_vld), .lsu_vld(lsu_vld),
        .lsu_wb_vld(lsu_wb_vld), .lsu_op(lsu_op), .lsu_wb_addr(lsu_wb_addr),
        .lsu_wb_data(lsu_wb_data), .lsu_store_data(lsu_store_data),
        .lsu_sram_addr(lsu_sram_addr), .lsu_sram_sel(lsu_sram_sel)
    );

endmodule

/* tb_exec_stage.sv */
`timescale 1ns/1ps

module tb_exec_stage;

    import exec_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        idu_vld = 1'b0, idu_wb_en = 1'b0, lsu_rdy = 1'b1;
    logic [4:0]  idu_wb_addr = 5'h0;
    logic [31:0] idu_src1 = 32'h0, idu_src2 = 32'h0, idu_imm = 32'h0, idu_pc = 32'h0;
    alu_op_e     idu_op = OP_NOP;
    logic        idu_rdy, idu_flush, wb_vld, wb_is_load, ifu_br_vld, lsu_vld, lsu_wb_vld;
    logic [4:0]  wb_addr, lsu_wb_addr;
    logic [11:0] ifu_br_addr, lsu_sram_addr;
    logic [31:0] wb_data, lsu_wb_data, lsu_store_data;
    alu_op_e     lsu_op;
    sram_sel_e   lsu_sram_sel;
    int          errors = 0, checks = 0, cycles = 0;

    exec_stage i_exec_stage (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // expected results from the opcode rules
    function automatic logic [31:0] alu_expect(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                               logic [31:0] pc);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a + ~b + 32'd1;
            OP_SLT:   return {31'h0, (a[31] != b[31]) ? a[31] : (a < b)};
            OP_SLTU:  return {31'h0, a < b};
            OP_XOR:   return a ^ b;
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_SRA:   return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            OP_LUI:   return b;
            OP_AUIPC: return pc + b;
            default:  return 32'h0;
        endcase
    endfunction

    task automatic present(input alu_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                           input logic [31:0] imm, input logic [31:0] pc, input logic wb_en);
        @(posedge clk);
        #1;
        idu_vld     = 1'b1;
        idu_op      = op;
        idu_src1    = s1;
        idu_src2    = s2;
        idu_imm     = imm;
        idu_pc      = pc;
        idu_wb_en   = wb_en;
        idu_wb_addr = 5'($urandom());
        #1;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        idu_vld = 1'b0;
        idu_op  = OP_NOP;
        #1;
    endtask

    task automatic alu_test();
        alu_op_e     ops [12];
        logic [31:0] a, b;
        logic        en;
        ops = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND, OP_SLL, OP_SRL,
                OP_SRA, OP_LUI, OP_AUIPC};
        foreach (ops[i]) begin
            for (int k = 0; k < 4; k++) begin
                a  = $urandom();
                b  = $urandom();
                en = k[0];
                // opposite sign bits for slt
                if (ops[i] == OP_SLT) begin
                    a[31] = k[1];
                    b[31] = !k[1];
                end
                present(ops[i], a, b, 32'h0, 32'h0000_1000 + 32'(4 * k), en);
                check("wb_data", wb_data, alu_expect(ops[i], a, b, idu_pc));
                check("wb_vld, wb_addr", {26'h0, wb_vld, wb_addr}, {26'h0, en, idu_wb_addr});
            end
        end
    endtask

    // control op at pc 0x800, then an add that a redirect must drop
    task automatic ctrl_case(input alu_op_e op, input logic [31:0] s1, input logic [31:0] s2,
                             input logic [31:0] imm, input logic taken, input logic [31:0] target);
        present(op, s1, s2, imm, 32'h0000_0800, 1'b1);
        if (op == OP_JAL || op == OP_JALR) begin
            check("link value", wb_data, 32'h0000_0804);
        end
        present(OP_ADD, s1, s2, 32'h0, 32'h0000_0804, 1'b1);
        check("ifu_br_vld, idu_flush, wb_vld", {29'h0, ifu_br_vld, idu_flush, wb_vld},
              {29'h0, taken, taken, !taken});
        if (taken) begin
            check("ifu_br_addr", 32'(ifu_br_addr), {20'h0, target[11:0]});
        end
        idle();
        check("lsu_vld, ifu_br_vld", {30'h0, lsu_vld, ifu_br_vld}, {30'h0, !taken, 1'b0});
    endtask

    task automatic branch_test();
        logic [31:0] a;
        a = $urandom();
        ctrl_case(OP_BEQ, a, a, 32'h0000_0124, 1'b1, 32'h0000_0924);
        ctrl_case(OP_BEQ, a, ~a, 32'h0000_0124, 1'b0, 32'h0);
        ctrl_case(OP_BNE, a, ~a, 32'hffff_ff00, 1'b1, 32'h0000_0700);
        ctrl_case(OP_BLT, 32'hffff_fff0, 32'h10, 32'h40, 1'b1, 32'h840);
        ctrl_case(OP_BGE, 32'h8000_0000, 32'h7fff_ffff, 32'h3c, 1'b0, 32'h0);
        ctrl_case(OP_BGE, a, a, 32'h3c, 1'b1, 32'h83c);
        ctrl_case(OP_BLTU, 32'hffff_fff0, 32'h10, 32'h7f0, 1'b0, 32'h0);
        ctrl_case(OP_BGEU, 32'hffff_ffff, 32'h1, 32'h20, 1'b1, 32'h820);
        ctrl_case(OP_JAL, a, 32'h0000_0ff0, 32'h0, 1'b1, 32'h0000_17f0);
        ctrl_case(OP_JALR, 32'h0000_2000, 32'h58, 32'h0, 1'b1, 32'h0000_2058);
    endtask

    task automatic mem_test();
        alu_op_e     ops [8];
        logic [31:0] a, b, imm, addr;
        logic        ld;
        ops = '{OP_LB, OP_SB, OP_LH, OP_SH, OP_LW, OP_SW, OP_LBU, OP_LHU};
        for (int k = 0; k < 2; k++) begin
            foreach (ops[i]) begin
                addr          = $urandom();
                addr[13:12]   = 2'(i + k);
                a             = $urandom();
                ld            = ops[i] inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
                // loads take the offset from src2, stores from imm
                b             = ld ? addr - a : $urandom();
                imm           = ld ? $urandom() : addr - a;
                present(ops[i], a, b, imm, 32'h0000_0200, ld);
                check("wb_is_load", 32'(wb_is_load), 32'(ld));
                idle();
                check("lsu_vld, lsu_op", {26'h0, lsu_vld, lsu_op}, {26'h0, 1'b1, ops[i]});
                check("lsu_wb_vld, lsu_wb_addr", {26'h0, lsu_wb_vld, lsu_wb_addr},
                      {26'h0, ld, idu_wb_addr});
                check("lsu_sram_sel, lsu_sram_addr", {18'h0, lsu_sram_sel, lsu_sram_addr},
                      {18'h0, addr[13:0]});
                if (!ld) begin
                    check("lsu_store_data", lsu_store_data, b);
                end
            end
        end
    endtask

    task automatic stall_test();
        logic [31:0] a, b;
        a = $urandom();
        b = $urandom();
        present(OP_ADD, a, b, 32'h0, 32'h0, 1'b1);
        @(posedge clk);
        #1;
        // sub waits behind the stalled add
        lsu_rdy  = 1'b0;
        idu_op   = OP_SUB;
        idu_src1 = b;
        idu_src2 = a;
        repeat (3) begin
            #1;
            check("idu_rdy, wb_vld, lsu_vld, lsu_wb_vld",
                  {28'h0, idu_rdy, wb_vld, lsu_vld, lsu_wb_vld}, 32'h3);
            check("held lsu_op", 32'(lsu_op), 32'(OP_ADD));
            check("held lsu_wb_data", lsu_wb_data, a + b);
            @(posedge clk);
            #1;
        end
        lsu_rdy = 1'b1;
        #1;
        check("sub accepted", {31'h0, wb_vld}, 32'h1);
        check("sub wb_data", wb_data, b - a);
        idle();
        check("sub lsu_vld, lsu_op", {26'h0, lsu_vld, lsu_op}, {26'h0, 1'b1, OP_SUB});
        check("sub lsu_wb_data", lsu_wb_data, b - a);
        idle();
        check("lsu_vld drained", 32'(lsu_vld), 32'h0);
    endtask

    initial begin
        void'($urandom(32'hda6b_acd5));
        repeat (5) @(posedge clk);
        #1;
        check("valids in reset", {29'h0, lsu_vld, lsu_wb_vld, ifu_br_vld}, 32'h0);
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle();
        check("valids after reset", {29'h0, lsu_vld, lsu_wb_vld, ifu_br_vld}, 32'h0);
        alu_test();
        branch_test();
        mem_test();
        stall_test();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
exec_pkg.sv
int_alu.sv
branch_resolve.sv
mem_addr_gen.sv
ex_lsu_reg.sv
exec_stage.sv
tb_exec_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_exec_stage -f vlog.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "Simulation passed"
